/* compile.f */
source/csr_addr_pkg.sv
source/csr_types_pkg.sv
source/csr_write_arbiter.sv
source/csr_trap_regs.sv
source/csr_super_regs.sv
source/csr_counters.sv
source/csr_read_mux.sv
source/csr_file.sv
test/csr_file_chk.sv
test/csr_file_tb.sv

/* source/csr_addr_pkg.sv */
`default_nettype none

package csr_addr_pkg;

  typedef logic [11:0] csr_addr_t;

  // Machine information, read only
  localparam csr_addr_t ADDR_MVENDORID     = 12'hF11;
  localparam csr_addr_t ADDR_MARCHID       = 12'hF12;
  localparam csr_addr_t ADDR_MIMPID        = 12'hF13;
  localparam csr_addr_t ADDR_MHARTID       = 12'hF14;

  // Machine trap setup
  localparam csr_addr_t ADDR_MSTATUS       = 12'h300;
  localparam csr_addr_t ADDR_MISA          = 12'h301;
  localparam csr_addr_t ADDR_MEDELEG       = 12'h302;
  localparam csr_addr_t ADDR_MIDELEG       = 12'h303;
  localparam csr_addr_t ADDR_MIE           = 12'h304;
  localparam csr_addr_t ADDR_MTVEC         = 12'h305;
  localparam csr_addr_t ADDR_MCOUNTINHIBIT = 12'h320;

  // Machine trap handling
  localparam csr_addr_t ADDR_MSCRATCH      = 12'h340;
  localparam csr_addr_t ADDR_MEPC          = 12'h341;
  localparam csr_addr_t ADDR_MCAUSE        = 12'h342;
  localparam csr_addr_t ADDR_MTVAL         = 12'h343;
  localparam csr_addr_t ADDR_MIP           = 12'h344;

  // Machine counters, low and high halves
  localparam csr_addr_t ADDR_MCYCLE        = 12'hB00;
  localparam csr_addr_t ADDR_MINSTRET      = 12'hB02;
  localparam csr_addr_t ADDR_MCYCLEH       = 12'hB80;
  localparam csr_addr_t ADDR_MINSTRETH     = 12'hB82;

  // Supervisor
  localparam csr_addr_t ADDR_SSTATUS       = 12'h100;
  localparam csr_addr_t ADDR_SIE           = 12'h104;
  localparam csr_addr_t ADDR_STVEC         = 12'h105;
  localparam csr_addr_t ADDR_SSCRATCH      = 12'h140;
  localparam csr_addr_t ADDR_SEPC          = 12'h141;
  localparam csr_addr_t ADDR_SCAUSE        = 12'h142;
  localparam csr_addr_t ADDR_STVAL         = 12'h143;
  localparam csr_addr_t ADDR_SIP           = 12'h144;
  localparam csr_addr_t ADDR_SATP          = 12'h180;

  localparam logic [31:0] MVENDORID_VAL = 32'h0004_4198;
  localparam logic [31:0] MARCHID_VAL   = 32'h0000_0001;
  localparam logic [31:0] MIMPID_VAL    = 32'h0000_0002;
  localparam logic [31:0] MHARTID_VAL   = 32'h0000_0000;
  localparam logic [31:0] MISA_VAL      = 32'h4000_1101;  // RV32IMA

endpackage

`default_nettype wire

/* source/csr_counters.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_counters (
  input  logic                          clk,
  input  logic                          rst,
  input  csr_types_pkg::csr_wr_req_t    wr,
  input  logic                          retire,
  output csr_types_pkg::counter_csrs_t  counters
);
  import csr_types_pkg::*;
  import csr_addr_pkg::*;

  logic wr_cycle_lo, wr_cycle_hi;
  logic wr_instret_lo, wr_instret_hi;
  logic wr_inhibit;

  assign wr_cycle_lo   = wr.en && (wr.addr == ADDR_MCYCLE);
  assign wr_cycle_hi   = wr.en && (wr.addr == ADDR_MCYCLEH);
  assign wr_instret_lo = wr.en && (wr.addr == ADDR_MINSTRET);
  assign wr_instret_hi = wr.en && (wr.addr == ADDR_MINSTRETH);
  assign wr_inhibit    = wr.en && (wr.addr == ADDR_MCOUNTINHIBIT);

  always_ff @(posedge clk) begin
    if (rst) begin
      counters <= '0;  // Inhibit clear, both counters run from reset
    end else begin
      // A write wins over the increment on the same edge
      if (wr_cycle_lo) begin
        counters.mcycle[31:0] <= wr.data;
      end else if (wr_cycle_hi) begin
        counters.mcycle[63:32] <= wr.data;
      end else if (!counters.mcountinhibit[0]) begin
        counters.mcycle <= counters.mcycle + 64'd1;
      end

      if (wr_instret_lo) begin
        counters.minstret[31:0] <= wr.data;
      end else if (wr_instret_hi) begin
        counters.minstret[63:32] <= wr.data;
      end else if (retire && !counters.mcountinhibit[2]) begin
        counters.minstret <= counters.minstret + 64'd1;
      end

      if (wr_inhibit) begin
        counters.mcountinhibit <= merge_masked(counters.mcountinhibit, wr.data,
                                               MCOUNTINHIBIT_WMASK);
      end
    end
  end

endmodule

`default_nettype wire

/* source/csr_file.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_file (
  input  logic                        clk,
  input  logic                        rst,
  input  csr_types_pkg::csr_wr_req_t  core_wr,
  input  csr_types_pkg::csr_wr_req_t  clint_wr,
  input  logic                        retire,
  input  csr_addr_pkg::csr_addr_t     rd_addr,
  output csr_types_pkg::csr_word_t    rd_data,
  output logic                        rd_error,
  output csr_types_pkg::trap_csrs_t   trap_csrs,
  output csr_types_pkg::super_csrs_t  super_csrs,
  output csr_types_pkg::priv_t        privilege,
  output csr_types_pkg::mmu_ctrl_t    mmu_ctrl
);
  import csr_types_pkg::*;

  csr_wr_req_t   wr;        // Granted write, shared by all groups
  counter_csrs_t counters;

  csr_write_arbiter u_arbiter (
    .core_wr  (core_wr),
    .clint_wr (clint_wr),
    .wr       (wr)
  );

  csr_trap_regs u_trap (
    .clk       (clk),
    .rst       (rst),
    .wr        (wr),
    .trap_csrs (trap_csrs),
    .privilege (privilege),
    .mmu_ctrl  (mmu_ctrl)
  );

  csr_super_regs u_super (
    .clk        (clk),
    .rst        (rst),
    .wr         (wr),
    .super_csrs (super_csrs)
  );

  csr_counters u_counters (
    .clk      (clk),
    .rst      (rst),
    .wr       (wr),
    .retire   (retire),
    .counters (counters)
  );

  // Same-cycle read of the registered state
  csr_read_mux u_read_mux (
    .rd_addr    (rd_addr),
    .trap_csrs  (trap_csrs),
    .super_csrs (super_csrs),
    .counters   (counters),
    .rd_data    (rd_data),
    .rd_error   (rd_error)
  );

endmodule

`default_nettype wire

/* source/csr_read_mux.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_read_mux (
  input  csr_addr_pkg::csr_addr_t        rd_addr,
  input  csr_types_pkg::trap_csrs_t      trap_csrs,
  input  csr_types_pkg::super_csrs_t     super_csrs,
  input  csr_types_pkg::counter_csrs_t   counters,
  output csr_types_pkg::csr_word_t       rd_data,
  output logic                           rd_error
);
  import csr_types_pkg::*;
  import csr_addr_pkg::*;

  always_comb begin
    rd_data  = '0;
    rd_error = 1'b0;
    case (rd_addr)
      // Identification, constants only
      ADDR_MVENDORID:     rd_data = MVENDORID_VAL;
      ADDR_MARCHID:       rd_data = MARCHID_VAL;
      ADDR_MIMPID:        rd_data = MIMPID_VAL;
      ADDR_MHARTID:       rd_data = MHARTID_VAL;
      ADDR_MISA:          rd_data = MISA_VAL;

      ADDR_MSTATUS:       rd_data = trap_csrs.mstatus;
      ADDR_MEDELEG:       rd_data = trap_csrs.medeleg;
      ADDR_MIDELEG:       rd_data = trap_csrs.mideleg;
      ADDR_MIE:           rd_data = trap_csrs.mie;
      ADDR_MTVEC:         rd_data = trap_csrs.mtvec;
      ADDR_MSCRATCH:      rd_data = trap_csrs.mscratch;
      ADDR_MEPC:          rd_data = trap_csrs.mepc;
      ADDR_MCAUSE:        rd_data = trap_csrs.mcause;
      ADDR_MTVAL:         rd_data = trap_csrs.mtval;
      ADDR_MIP:           rd_data = trap_csrs.mip;

      // Counter halves
      ADDR_MCYCLE:        rd_data = counters.mcycle[31:0];
      ADDR_MCYCLEH:       rd_data = counters.mcycle[63:32];
      ADDR_MINSTRET:      rd_data = counters.minstret[31:0];
      ADDR_MINSTRETH:     rd_data = counters.minstret[63:32];
      ADDR_MCOUNTINHIBIT: rd_data = counters.mcountinhibit;

      ADDR_SSTATUS:       rd_data = super_csrs.sstatus;
      ADDR_SIE:           rd_data = super_csrs.sie;
      ADDR_SIP:           rd_data = super_csrs.sip;
      ADDR_STVEC:         rd_data = super_csrs.stvec;
      ADDR_SEPC:          rd_data = super_csrs.sepc;
      ADDR_SCAUSE:        rd_data = super_csrs.scause;
      ADDR_STVAL:         rd_data = super_csrs.stval;
      ADDR_SSCRATCH:      rd_data = super_csrs.sscratch;
      ADDR_SATP:          rd_data = super_csrs.satp;

      default: begin
        // Unimplemented, data stays zero
        rd_error = 1'b1;
      end
    endcase
  end

endmodule

`default_nettype wire

/* source/csr_super_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_super_regs (
  input  logic                        clk,
  input  logic                        rst,
  input  csr_types_pkg::csr_wr_req_t  wr,
  output csr_types_pkg::super_csrs_t  super_csrs
);
  import csr_types_pkg::*;
  import csr_addr_pkg::*;

  csr_word_t sstatus_next;
  csr_word_t sie_next;
  csr_word_t sip_next;

  // sstatus is its own register here, not a view of mstatus
  assign sstatus_next = merge_masked(super_csrs.sstatus, wr.data, SSTATUS_WMASK);
  assign sie_next     = merge_masked(super_csrs.sie, wr.data, SIE_WMASK);
  assign sip_next     = merge_masked(super_csrs.sip, wr.data, SIP_WMASK);

  always_ff @(posedge clk) begin
    if (rst) begin
      super_csrs <= '0;
    end else if (wr.en) begin
      case (wr.addr)
        ADDR_SSTATUS:  super_csrs.sstatus  <= sstatus_next;
        ADDR_SIE:      super_csrs.sie      <= sie_next;
        ADDR_SIP:      super_csrs.sip      <= sip_next;
        ADDR_STVEC:    super_csrs.stvec    <= wr.data;
        ADDR_SEPC:     super_csrs.sepc     <= wr.data;
        ADDR_SCAUSE:   super_csrs.scause   <= wr.data;
        ADDR_STVAL:    super_csrs.stval    <= wr.data;
        ADDR_SSCRATCH: super_csrs.sscratch <= wr.data;
        ADDR_SATP:     super_csrs.satp     <= wr.data;  // Sv32 MODE, ASID, PPN all writable
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

/* source/csr_trap_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_trap_regs (
  input  logic                        clk,
  input  logic                        rst,
  input  csr_types_pkg::csr_wr_req_t  wr,
  output csr_types_pkg::trap_csrs_t   trap_csrs,
  output csr_types_pkg::priv_t        privilege,
  output csr_types_pkg::mmu_ctrl_t    mmu_ctrl
);
  import csr_types_pkg::*;
  import csr_addr_pkg::*;

  csr_word_t mstatus_next;
  csr_word_t mie_next;
  csr_word_t mip_next;

  assign mstatus_next = merge_masked(trap_csrs.mstatus, wr.data, MSTATUS_WMASK);
  assign mie_next     = merge_masked(trap_csrs.mie, wr.data, MIE_WMASK);
  assign mip_next     = merge_masked(trap_csrs.mip, wr.data, MIP_WMASK);

  always_ff @(posedge clk) begin
    if (rst) begin
      trap_csrs         <= '0;
      trap_csrs.mstatus <= MSTATUS_RESET;
      privilege         <= PRIV_MACHINE;
    end else if (wr.en) begin
      case (wr.addr)
        ADDR_MSTATUS: begin
          trap_csrs.mstatus <= mstatus_next;
          // Privilege tracks MPP on every mstatus write
          privilege <= mstatus_next[MSTATUS_MPP_LSB +: 2];
        end
        ADDR_MIE:      trap_csrs.mie      <= mie_next;
        ADDR_MIP:      trap_csrs.mip      <= mip_next;  // Only SSIP is software writable
        ADDR_MEDELEG:  trap_csrs.medeleg  <= wr.data;
        ADDR_MIDELEG:  trap_csrs.mideleg  <= wr.data;
        ADDR_MTVEC:    trap_csrs.mtvec    <= wr.data;
        ADDR_MSCRATCH: trap_csrs.mscratch <= wr.data;
        ADDR_MEPC:     trap_csrs.mepc     <= wr.data;
        ADDR_MCAUSE:   trap_csrs.mcause   <= wr.data;
        ADDR_MTVAL:    trap_csrs.mtval    <= wr.data;
        default: ;  // Not a machine trap register
      endcase
    end
  end

  // MMU controls straight from mstatus
  assign mmu_ctrl.mxr = trap_csrs.mstatus[MSTATUS_MXR];
  assign mmu_ctrl.sum = trap_csrs.mstatus[MSTATUS_SUM];
  assign mmu_ctrl.tvm = trap_csrs.mstatus[MSTATUS_TVM];
  assign mmu_ctrl.tw  = trap_csrs.mstatus[MSTATUS_TW];
  assign mmu_ctrl.tsr = trap_csrs.mstatus[MSTATUS_TSR];

endmodule

`default_nettype wire

/* source/csr_types_pkg.sv */
`default_nettype none

package csr_types_pkg;

  typedef logic [31:0] csr_word_t;
  typedef logic [63:0] counter_t;
  typedef logic [1:0]  priv_t;

  localparam priv_t     PRIV_MACHINE  = 2'b11;
  localparam csr_word_t MSTATUS_RESET = 32'h0000_1800;  // MPP = machine

  // Writable bits, everything else holds
  localparam csr_word_t MSTATUS_WMASK       = 32'h807F_F9EA;
  localparam csr_word_t SSTATUS_WMASK       = 32'h800D_E122;
  localparam csr_word_t MIE_WMASK           = 32'h0000_0AAA;
  localparam csr_word_t SIE_WMASK           = 32'h0000_0222;
  localparam csr_word_t MIP_WMASK           = 32'h0000_0002;  // SSIP only
  localparam csr_word_t SIP_WMASK           = 32'h0000_0002;
  localparam csr_word_t MCOUNTINHIBIT_WMASK = 32'h0000_0005;  // CY and IR

  // mstatus field positions
  localparam int MSTATUS_MPP_LSB = 11;
  localparam int MSTATUS_TSR     = 22;
  localparam int MSTATUS_TW      = 21;
  localparam int MSTATUS_TVM     = 20;
  localparam int MSTATUS_MXR     = 19;
  localparam int MSTATUS_SUM     = 18;

  typedef enum logic [1:0] {
    SRC_NONE,
    SRC_CORE,
    SRC_CLINT
  } wr_src_t;

  typedef struct packed {
    logic                   en;
    csr_addr_pkg::csr_addr_t addr;
    csr_word_t              data;
  } csr_wr_req_t;

  typedef struct packed {
    csr_word_t mstatus;
    csr_word_t mtvec;
    csr_word_t mepc;
    csr_word_t mcause;
    csr_word_t mtval;
    csr_word_t mie;
    csr_word_t mip;
    csr_word_t medeleg;
    csr_word_t mideleg;
    csr_word_t mscratch;
  } trap_csrs_t;

  typedef struct packed {
    csr_word_t sstatus;
    csr_word_t sie;
    csr_word_t sip;
    csr_word_t stvec;
    csr_word_t sepc;
    csr_word_t scause;
    csr_word_t stval;
    csr_word_t sscratch;
    csr_word_t satp;
  } super_csrs_t;

  typedef struct packed {
    counter_t  mcycle;
    counter_t  minstret;
    csr_word_t mcountinhibit;
  } counter_csrs_t;

  typedef struct packed {
    logic mxr;
    logic sum;
    logic tvm;
    logic tw;
    logic tsr;
  } mmu_ctrl_t;

  // New bits under the mask, old bits elsewhere
  function automatic csr_word_t merge_masked(csr_word_t old_val, csr_word_t new_val,
                                             csr_word_t mask);
    return (old_val & ~mask) | (new_val & mask);
  endfunction

endpackage

`default_nettype wire

/* source/csr_write_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_write_arbiter (
  input  csr_types_pkg::csr_wr_req_t core_wr,
  input  csr_types_pkg::csr_wr_req_t clint_wr,
  output csr_types_pkg::csr_wr_req_t wr
);
  import csr_types_pkg::*;
  import csr_addr_pkg::*;

  wr_src_t src;
  logic    clint_allowed;

  // CLINT wins any collision
  always_comb begin
    if (clint_wr.en) begin
      src = SRC_CLINT;
    end else if (core_wr.en) begin
      src = SRC_CORE;
    end else begin
      src = SRC_NONE;
    end
  end

  // Registers the CLINT touches on trap entry and return
  always_comb begin
    case (clint_wr.addr)
      ADDR_MSTATUS, ADDR_MTVEC, ADDR_MSCRATCH, ADDR_MEPC, ADDR_MCAUSE,
      ADDR_MTVAL, ADDR_MIP, ADDR_SSTATUS, ADDR_STVEC, ADDR_SSCRATCH,
      ADDR_SEPC, ADDR_SCAUSE, ADDR_STVAL, ADDR_SIP, ADDR_SATP: begin
        clint_allowed = 1'b1;
      end
      default: clint_allowed = 1'b0;
    endcase
  end

  always_comb begin
    case (src)
      SRC_CLINT: begin
        wr    = clint_wr;
        wr.en = clint_allowed;  // Denied request still blocks the core
      end
      SRC_CORE: wr = core_wr;
      default:  wr = '0;
    endcase
  end

endmodule

`default_nettype wire

/* test/csr_file_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_file_chk (
  input logic                        clk,
  input logic                        rst,
  input csr_types_pkg::csr_wr_req_t  core_wr,
  input csr_types_pkg::csr_wr_req_t  clint_wr,
  input csr_types_pkg::csr_wr_req_t  wr,
  input csr_types_pkg::trap_csrs_t   trap_csrs,
  input csr_types_pkg::super_csrs_t  super_csrs,
  input csr_types_pkg::priv_t        privilege
);
  import csr_types_pkg::*;

  int unsigned failures = 0;

  // mstatus is the top field, MPP set to machine
  a_trap_reset: assert property (@(posedge clk)
    rst |=> (trap_csrs == trap_csrs_t'({32'h0000_1800, 288'd0})) && (privilege == 2'b11))
    else begin
      $error("Machine trap registers or privilege not at reset value");
      failures++;
    end

  a_super_reset: assert property (@(posedge clk) rst |=> (super_csrs == '0))
    else begin
      $error("Supervisor registers not cleared by reset");
      failures++;
    end

  // Core request dropped on a collision
  a_clint_wins: assert property (@(posedge clk) disable iff (rst)
    (clint_wr.en && core_wr.en) |-> (wr.addr == clint_wr.addr) && (wr.data == clint_wr.data))
    else begin
      $error("Core write granted while the CLINT was requesting");
      failures++;
    end

  a_core_alone: assert property (@(posedge clk) disable iff (rst)
    (core_wr.en && !clint_wr.en) |-> (wr == core_wr))
    else begin
      $error("Lone core request not passed through");
      failures++;
    end

  a_idle: assert property (@(posedge clk) disable iff (rst)
    !(core_wr.en || clint_wr.en) |-> !wr.en)
    else begin
      $error("Write granted with no request");
      failures++;
    end

endmodule

bind csr_file csr_file_chk u_chk (
  .clk        (clk),
  .rst        (rst),
  .core_wr    (core_wr),
  .clint_wr   (clint_wr),
  .wr         (wr),
  .trap_csrs  (trap_csrs),
  .super_csrs (super_csrs),
  .privilege  (privilege)
);

`default_nettype wire

/* test/csr_file_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_file_tb;
  import csr_types_pkg::*;
  import csr_addr_pkg::*;

  localparam int HALF_PERIOD  = 2;
  localparam int EDGE_TIMEOUT = 40;  // ns allowed for one clock edge

  // Legal bits per register
  localparam logic [31:0] MSTATUS_LEGAL = 32'h807F_F9EA;
  localparam logic [31:0] SSTATUS_LEGAL = 32'h800D_E122;
  localparam logic [31:0] MIE_LEGAL     = 32'h0000_0AAA;
  localparam logic [31:0] SIE_LEGAL     = 32'h0000_0222;
  localparam logic [31:0] IP_LEGAL      = 32'h0000_0002;  // mip and sip
  localparam logic [31:0] INHIBIT_LEGAL = 32'h0000_0005;

  typedef enum logic [1:0] {BY_CORE, BY_CLINT, BY_BOTH} src_sel_t;

  typedef struct packed {
    src_sel_t    src;
    logic [11:0] addr;
    logic [31:0] data;       // CLINT data when both write
    logic [31:0] core_data;  // Only used on a collision
    logic [31:0] exp_data;
    logic        exp_err;
  } row_t;

  logic          clk;
  logic          rst;
  csr_wr_req_t   core_wr;
  csr_wr_req_t   clint_wr;
  logic          retire;
  csr_addr_t     rd_addr;
  csr_word_t     rd_data;
  logic          rd_error;
  trap_csrs_t    trap_csrs;
  super_csrs_t   super_csrs;
  priv_t         privilege;
  mmu_ctrl_t     mmu_ctrl;

  logic [31:0] rng_state;
  logic        edge_seen;
  row_t        rows[$];
  string       names[$];
  logic [1:0]  exp_priv;
  logic [4:0]  exp_mmu;   // mxr, sum, tvm, tw, tsr

  csr_file dut (
    .clk        (clk),
    .rst        (rst),
    .core_wr    (core_wr),
    .clint_wr   (clint_wr),
    .retire     (retire),
    .rd_addr    (rd_addr),
    .rd_data    (rd_data),
    .rd_error   (rd_error),
    .trap_csrs  (trap_csrs),
    .super_csrs (super_csrs),
    .privilege  (privilege),
    .mmu_ctrl   (mmu_ctrl)
  );

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // One rising edge, bounded in time
  task next_edge();
    edge_seen = 1'b0;
    fork
      begin
        @(posedge clk);
        edge_seen = 1'b1;
      end
      #EDGE_TIMEOUT;
    join_any
    disable fork;
    if (!edge_seen) begin
      $display("Timeout: no rising clock edge within %0d ns", EDGE_TIMEOUT);
      $display("TESTBENCH FAILED");
      $fatal(1);
    end
  endtask

  task automatic wait_edges(input int n);
    int i;
    for (i = 0; i < n; i++) begin
      next_edge();
    end
  endtask

  task automatic check_word(input string name, input logic [31:0] exp_val,
                            input logic [31:0] act_val);
    assert (act_val === exp_val) else begin
      $display("FAIL %s: expected 0x%08h, actual 0x%08h", name, exp_val, act_val);
      $display("TESTBENCH FAILED");
      $fatal(1);
    end
  endtask

  // Output struct copy of the register at addr, top bit set when there is one
  function automatic logic [32:0] struct_field(input csr_addr_t addr);
    case (addr)
      ADDR_MSTATUS:  return {1'b1, trap_csrs.mstatus};
      ADDR_MIE:      return {1'b1, trap_csrs.mie};
      ADDR_MIP:      return {1'b1, trap_csrs.mip};
      ADDR_MEPC:     return {1'b1, trap_csrs.mepc};
      ADDR_MEDELEG:  return {1'b1, trap_csrs.medeleg};
      ADDR_MSCRATCH: return {1'b1, trap_csrs.mscratch};
      ADDR_SSTATUS:  return {1'b1, super_csrs.sstatus};
      ADDR_SIE:      return {1'b1, super_csrs.sie};
      ADDR_SIP:      return {1'b1, super_csrs.sip};
      ADDR_SATP:     return {1'b1, super_csrs.satp};
      default:       return '0;
    endcase
  endfunction

  // Request held for one cycle, read address follows it
  task automatic apply_request(input logic core_en, input csr_word_t core_data,
                               input logic clint_en, input csr_word_t clint_data,
                               input csr_addr_t addr);
    next_edge();
    core_wr  <= '{en: core_en, addr: addr, data: core_data};
    clint_wr <= '{en: clint_en, addr: addr, data: clint_data};
    rd_addr  <= addr;
    next_edge();
    core_wr.en  <= 1'b0;
    clint_wr.en <= 1'b0;
  endtask

  task automatic add_row(input string name, input src_sel_t src, input csr_addr_t addr,
                         input csr_word_t data, input csr_word_t core_data,
                         input csr_word_t exp_data, input logic exp_err);
    rows.push_back(row_t'{src, addr, data, core_data, exp_data, exp_err});
    names.push_back(name);
  endtask

  task automatic build_table();
    csr_word_t r;
    csr_word_t keep;
    add_row("mstatus_ones", BY_CORE, ADDR_MSTATUS, '1, '0, MSTATUS_LEGAL, 1'b0);
    add_row("sstatus_ones", BY_CORE, ADDR_SSTATUS, '1, '0, SSTATUS_LEGAL, 1'b0);
    add_row("mie_ones", BY_CORE, ADDR_MIE, '1, '0, MIE_LEGAL, 1'b0);
    add_row("sie_ones", BY_CORE, ADDR_SIE, '1, '0, SIE_LEGAL, 1'b0);
    add_row("mip_ones", BY_CORE, ADDR_MIP, '1, '0, IP_LEGAL, 1'b0);
    add_row("mcountinhibit_ones", BY_CORE, ADDR_MCOUNTINHIBIT, '1, '0, INHIBIT_LEGAL, 1'b0);
    r = next_random();
    add_row("mstatus_random", BY_CORE, ADDR_MSTATUS, r, '0, r & MSTATUS_LEGAL, 1'b0);
    add_row("mstatus_super", BY_CLINT, ADDR_MSTATUS, 32'h0004_0800, '0, 32'h0004_0800, 1'b0);
    r = next_random();
    add_row("mepc_both", BY_BOTH, ADDR_MEPC, r, next_random(), r, 1'b0);
    r = next_random();
    keep = r & MIE_LEGAL;
    add_row("mie_core", BY_CORE, ADDR_MIE, r, '0, keep, 1'b0);
    add_row("mie_clint", BY_CLINT, ADDR_MIE, next_random(), '0, keep, 1'b0);
    r = next_random();
    add_row("medeleg_core", BY_CORE, ADDR_MEDELEG, r, '0, r, 1'b0);
    add_row("medeleg_clint", BY_CLINT, ADDR_MEDELEG, next_random(), '0, r, 1'b0);
    r = next_random();
    add_row("mscratch_clint", BY_CLINT, ADDR_MSCRATCH, r, '0, r, 1'b0);
    r = next_random();
    add_row("satp_clint", BY_CLINT, ADDR_SATP, r, '0, r, 1'b0);
    r = next_random();
    add_row("sip_clint", BY_CLINT, ADDR_SIP, r, '0, r & IP_LEGAL, 1'b0);
    add_row("unimplemented", BY_CORE, 12'h7C0, next_random(), '0, '0, 1'b1);
    add_row("mvendorid", BY_CORE, ADDR_MVENDORID, next_random(), '0, MVENDORID_VAL, 1'b0);
    add_row("marchid", BY_CORE, ADDR_MARCHID, next_random(), '0, MARCHID_VAL, 1'b0);
    add_row("mimpid", BY_CORE, ADDR_MIMPID, next_random(), '0, MIMPID_VAL, 1'b0);
    add_row("mhartid", BY_CORE, ADDR_MHARTID, next_random(), '0, MHARTID_VAL, 1'b0);
    add_row("misa", BY_CORE, ADDR_MISA, next_random(), '0, MISA_VAL, 1'b0);
  endtask

  task automatic check_counters();
    csr_word_t first;
    csr_word_t v;
    csr_word_t w;
    logic [31:0] bits;
    int i;
    int k;
    // Cycle counter stopped, instret still allowed
    apply_request(1'b1, 32'h1, 1'b0, '0, ADDR_MCOUNTINHIBIT);
    rd_addr <= ADDR_MCYCLE;
    #1;
    first = rd_data;
    wait_edges(5);
    #1;
    check_word("mcycle_inhibited", first, rd_data);

    apply_request(1'b1, '0, 1'b0, '0, ADDR_MCOUNTINHIBIT);
    v = next_random();
    apply_request(1'b1, v, 1'b0, '0, ADDR_MCYCLE);
    #1;
    check_word("mcycle_load", v, rd_data);
    wait_edges(7);
    #1;
    check_word("mcycle_count", v + 32'd7, rd_data);

    w = next_random();
    apply_request(1'b1, w, 1'b0, '0, ADDR_MINSTRET);
    bits = next_random();
    k = 0;
    for (i = 0; i < 12; i++) begin
      retire <= bits[i];
      k = k + bits[i];
      next_edge();
    end
    retire <= 1'b0;
    #1;
    check_word("minstret_count", w + k, rd_data);
  endtask

  initial begin
    row_t row;
    logic [32:0] field;
    rst       = 1'b1;
    core_wr   = '0;
    clint_wr  = '0;
    retire    = 1'b0;
    rd_addr   = '0;
    rng_state = 32'd72513;
    exp_priv  = 2'b11;  // Machine after reset
    exp_mmu   = '0;
    wait_edges(3);
    rst <= 1'b0;
    build_table();

    foreach (rows[i]) begin
      row = rows[i];
      apply_request(row.src != BY_CLINT, (row.src == BY_BOTH) ? row.core_data : row.data,
                    row.src != BY_CORE, row.data, row.addr);
      if (row.addr == ADDR_MSTATUS) begin
        exp_priv = row.exp_data[12:11];
        exp_mmu  = {row.exp_data[19], row.exp_data[18], row.exp_data[20],
                    row.exp_data[21], row.exp_data[22]};
      end
      #1;
      check_word(names[i], row.exp_data, rd_data);
      check_word({names[i], " rd_error"}, {31'b0, row.exp_err}, {31'b0, rd_error});
      check_word({names[i], " privilege"}, {30'b0, exp_priv}, {30'b0, privilege});
      check_word({names[i], " mmu_ctrl"}, {27'b0, exp_mmu}, {27'b0, mmu_ctrl});
      field = struct_field(row.addr);
      if (field[32]) begin
        check_word({names[i], " struct output"}, row.exp_data, field[31:0]);
      end
    end

    check_counters();
    wait_edges(2);
    if (dut.u_chk.failures == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
